// File: design/btiger_pkg.sv
`default_nettype none

package btiger_pkg;

    // Counter and address widths
    typedef logic [8:0]  hcnt_t;
    typedef logic [8:0]  vcnt_t;
    typedef logic [25:0] dl_addr_t;

    // Palette in the upper nibble, color in the lower one, color 4'hF is transparent
    typedef logic [7:0]  pixel_t;

    // Layer code in bits 9:8, winning pixel below
    typedef logic [9:0]  pal_idx_t;

    typedef struct packed {
        pixel_t chr;
        pixel_t scr;
        pixel_t obj;
    } layer_pixels_t;

    typedef struct packed {
        hcnt_t h;
        vcnt_t v;
        logic  lhbl;
        logic  lvbl;
        logic  hs;
        logic  vs;
        logic  hinit;
    } vid_timing_t;

    typedef struct packed {
        logic       we;
        logic [7:0] addr;
        logic [3:0] data;
    } prom_wr_t;

    // Default video timing, 6 MHz pixel clock
    localparam int H_TOTAL     = 384;
    localparam int H_ACTIVE    = 256;
    localparam int V_TOTAL     = 262;
    localparam int V_ACT_START = 16;
    localparam int V_ACT_END   = 240;
    localparam int HS_START    = 288;
    localparam int HS_END      = 320;
    localparam int VS_START    = 248;
    localparam int VS_END      = 251;

    // Download memory map
    localparam dl_addr_t OBJ_START  = 26'h0A0000;
    localparam dl_addr_t PROM_START = 26'h0E0000;
    localparam dl_addr_t MCU_OVER   = PROM_START + 26'h1000;

endpackage

`default_nettype wire

// File: design/btiger_cen.sv
`timescale 1ns/100ps
`default_nettype none

module btiger_cen (
    input  logic clk,
    input  logic rst,
    output logic cen12,
    output logic cen6,
    output logic cen3
);

    logic [3:0] cnt;
    logic [3:0] cnt_nxt;

    assign cnt_nxt = cnt + 4'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else begin
            cnt <= cnt_nxt;
        end
    end

    // Decode the next count so each strobe lines up with counts 3, 7, 11 and 15
    always_ff @(posedge clk) begin
        if (rst) begin
            cen12 <= 1'b0;
            cen6  <= 1'b0;
            cen3  <= 1'b0;
        end else begin
            cen12 <= &cnt_nxt[1:0];
            cen6  <= &cnt_nxt[2:0];
            cen3  <= &cnt_nxt;
        end
    end

endmodule

`default_nettype wire

// File: design/btiger_timer.sv
`timescale 1ns/100ps
`default_nettype none

module btiger_timer #(
    parameter int H_TOTAL     = btiger_pkg::H_TOTAL,
    parameter int H_ACTIVE    = btiger_pkg::H_ACTIVE,
    parameter int V_TOTAL     = btiger_pkg::V_TOTAL,
    parameter int V_ACT_START = btiger_pkg::V_ACT_START,
    parameter int V_ACT_END   = btiger_pkg::V_ACT_END,
    parameter int HS_START    = btiger_pkg::HS_START,
    parameter int HS_END      = btiger_pkg::HS_END,
    parameter int VS_START    = btiger_pkg::VS_START,
    parameter int VS_END      = btiger_pkg::VS_END
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cen6,
    output btiger_pkg::vid_timing_t timing
);

    import btiger_pkg::*;

    hcnt_t h_nxt;
    vcnt_t v_nxt;
    logic  h_wrap;
    logic  v_wrap;

    // Half-open window check on a count
    function automatic logic in_window(input int val, input int lo, input int hi);
        return (val >= lo) && (val < hi);
    endfunction

    always_comb begin
        h_wrap = timing.h == hcnt_t'(H_TOTAL - 1);
        v_wrap = timing.v == vcnt_t'(V_TOTAL - 1);
        h_nxt  = h_wrap ? '0 : timing.h + 1'b1;
        v_nxt  = timing.v;
        // Line count steps once per wrapped line
        if (h_wrap) begin
            v_nxt = v_wrap ? '0 : timing.v + 1'b1;
        end
    end

    // Flags come from the next counts so they match h and v on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            timing.h     <= '0;
            timing.v     <= '0;
            timing.lhbl  <= 1'b1;
            timing.lvbl  <= 1'b0;
            timing.hs    <= 1'b0;
            timing.vs    <= 1'b0;
            timing.hinit <= 1'b0;
        end else if (cen6) begin
            timing.h     <= h_nxt;
            timing.v     <= v_nxt;
            timing.lhbl  <= in_window(int'(h_nxt), 0, H_ACTIVE);
            timing.lvbl  <= in_window(int'(v_nxt), V_ACT_START, V_ACT_END);
            timing.hs    <= in_window(int'(h_nxt), HS_START, HS_END);
            timing.vs    <= in_window(int'(v_nxt), VS_START, VS_END);
            // No line start pulse on the first line of the frame
            timing.hinit <= (h_nxt == '0) && (v_nxt != '0);
        end
    end

endmodule

`default_nettype wire

// File: design/btiger_rom_loader.sv
`timescale 1ns/100ps
`default_nettype none

module btiger_rom_loader #(
    parameter btiger_pkg::dl_addr_t OBJ_START = btiger_pkg::OBJ_START,
    parameter btiger_pkg::dl_addr_t MCU_OVER  = btiger_pkg::MCU_OVER
) (
    input  logic                 clk,
    input  logic                 rst,
    input  btiger_pkg::dl_addr_t ioctl_addr,
    input  logic [21:0]          prog_addr,
    input  logic [7:0]           prog_data,
    input  logic                 prom_we,
    output btiger_pkg::prom_wr_t prior_wr,
    output logic                 mcu_we,
    output logic [11:0]          mcu_addr,
    output logic [7:0]           mcu_data,
    output logic [21:0]          post_addr
);

    logic       mcu_over;
    logic [2:0] prom_page;
    logic       prior_sel;
    logic       mcu_sel;

    assign mcu_over  = ioctl_addr >= MCU_OVER;

    // PROM pages are 256 bytes apart above the MCU image
    assign prom_page = ioctl_addr[10:8];

    // Only page 0 is kept, the other pages fall through unused
    assign prior_sel = prom_we && mcu_over && (prom_page == 3'd0);
    assign mcu_sel   = prom_we && !mcu_over;

    always_ff @(posedge clk) begin
        prior_wr.addr <= prog_addr[7:0];
        prior_wr.data <= prog_data[3:0];
        mcu_addr      <= prog_addr[11:0];
        mcu_data      <= prog_data;
        if (rst) begin
            prior_wr.we <= 1'b0;
            mcu_we      <= 1'b0;
        end else begin
            prior_wr.we <= prior_sel;
            mcu_we      <= mcu_sel;
        end
    end

    // Object ROM bytes are stored with address bit 5 moved below bits 4 to 1
    always_comb begin
        post_addr = prog_addr;
        if (ioctl_addr >= OBJ_START) begin
            post_addr[5:1] = {prog_addr[4:1], prog_addr[5]};
        end
    end

endmodule

`default_nettype wire

// File: design/btiger_prio_mix.sv
`timescale 1ns/100ps
`default_nettype none

module btiger_prio_mix (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen6,
    input  btiger_pkg::prom_wr_t      prior_wr,
    input  btiger_pkg::layer_pixels_t pixels,
    input  logic                      lhbl,
    input  logic                      lvbl,
    output btiger_pkg::pal_idx_t      color
);

    import btiger_pkg::*;

    localparam logic [1:0] LAYER_BLANK = 2'b00;
    localparam logic [1:0] LAYER_CHR   = 2'b01;
    localparam logic [1:0] LAYER_SCR   = 2'b10;
    localparam logic [1:0] LAYER_OBJ   = 2'b11;

    localparam logic [3:0] TRANSPARENT = 4'hF;

    // Priority PROM, indexed by the scroll pixel
    logic [3:0] prio_rom [0:255];

    layer_pixels_t pix_q;
    logic          obj_under_q;
    logic          active_q;
    pal_idx_t      color_nxt;

    always_ff @(posedge clk) begin
        if (prior_wr.we) begin
            prio_rom[prior_wr.addr] <= prior_wr.data;
        end
    end

    // Stage one samples the layers and the PROM entry for this scroll pixel
    always_ff @(posedge clk) begin
        if (cen6) begin
            pix_q       <= pixels;
            obj_under_q <= prio_rom[pixels.scr][0];
        end
        if (rst) begin
            active_q <= 1'b0;
        end else if (cen6) begin
            active_q <= lhbl && lvbl;
        end
    end

    // Character on top, then objects unless the PROM hides them, scroll last
    always_comb begin
        if (!active_q) begin
            color_nxt = {LAYER_BLANK, 8'h00};
        end else if (pix_q.chr[3:0] != TRANSPARENT) begin
            color_nxt = {LAYER_CHR, pix_q.chr};
        end else if ((pix_q.obj[3:0] != TRANSPARENT) && !obj_under_q) begin
            color_nxt = {LAYER_OBJ, pix_q.obj};
        end else begin
            color_nxt = {LAYER_SCR, pix_q.scr};
        end
    end

    // Stage two
    always_ff @(posedge clk) begin
        if (rst) begin
            color <= '0;
        end else if (cen6) begin
            color <= color_nxt;
        end
    end

endmodule

`default_nettype wire

// File: design/btiger_video_top.sv
`timescale 1ns/100ps
`default_nettype none

module btiger_video_top #(
    parameter int                   H_TOTAL     = btiger_pkg::H_TOTAL,
    parameter int                   H_ACTIVE    = btiger_pkg::H_ACTIVE,
    parameter int                   V_TOTAL     = btiger_pkg::V_TOTAL,
    parameter int                   V_ACT_START = btiger_pkg::V_ACT_START,
    parameter int                   V_ACT_END   = btiger_pkg::V_ACT_END,
    parameter int                   HS_START    = btiger_pkg::HS_START,
    parameter int                   HS_END      = btiger_pkg::HS_END,
    parameter int                   VS_START    = btiger_pkg::VS_START,
    parameter int                   VS_END      = btiger_pkg::VS_END,
    parameter btiger_pkg::dl_addr_t OBJ_START   = btiger_pkg::OBJ_START,
    parameter btiger_pkg::dl_addr_t MCU_OVER    = btiger_pkg::MCU_OVER
) (
    input  logic                      clk,
    input  logic                      rst,
    // Download bus
    input  btiger_pkg::dl_addr_t      ioctl_addr,
    input  logic [21:0]               prog_addr,
    input  logic [7:0]                prog_data,
    input  logic                      prom_we,
    // Layer pixels from the tile and sprite generators
    input  btiger_pkg::layer_pixels_t pixels,
    output logic                      pxl2_cen,
    output logic                      pxl_cen,
    output logic                      cen3,
    output btiger_pkg::vid_timing_t   timing,
    output btiger_pkg::pal_idx_t      color,
    output logic                      mcu_we,
    output logic [11:0]               mcu_addr,
    output logic [7:0]                mcu_data,
    output logic [21:0]               post_addr
);

    import btiger_pkg::*;

    prom_wr_t prior_wr;

    btiger_cen u_cen (
        .clk   (clk),
        .rst   (rst),
        .cen12 (pxl2_cen),
        .cen6  (pxl_cen),
        .cen3  (cen3)
    );

    btiger_timer #(
        .H_TOTAL     (H_TOTAL),
        .H_ACTIVE    (H_ACTIVE),
        .V_TOTAL     (V_TOTAL),
        .V_ACT_START (V_ACT_START),
        .V_ACT_END   (V_ACT_END),
        .HS_START    (HS_START),
        .HS_END      (HS_END),
        .VS_START    (VS_START),
        .VS_END      (VS_END)
    ) u_timer (
        .clk    (clk),
        .rst    (rst),
        .cen6   (pxl_cen),
        .timing (timing)
    );

    btiger_rom_loader #(
        .OBJ_START (OBJ_START),
        .MCU_OVER  (MCU_OVER)
    ) u_loader (
        .clk        (clk),
        .rst        (rst),
        .ioctl_addr (ioctl_addr),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .prom_we    (prom_we),
        .prior_wr   (prior_wr),
        .mcu_we     (mcu_we),
        .mcu_addr   (mcu_addr),
        .mcu_data   (mcu_data),
        .post_addr  (post_addr)
    );

    btiger_prio_mix u_mix (
        .clk      (clk),
        .rst      (rst),
        .cen6     (pxl_cen),
        .prior_wr (prior_wr),
        .pixels   (pixels),
        .lhbl     (timing.lhbl),
        .lvbl     (timing.lvbl),
        .color    (color)
    );

endmodule

`default_nettype wire

// File: verification/btiger_assert.sv
`timescale 1ns/100ps
`default_nettype none

// The timer's cen6 input is the strobe from btiger_cen
module btiger_assert #(
    parameter int H_TOTAL = btiger_pkg::H_TOTAL,
    parameter int V_TOTAL = btiger_pkg::V_TOTAL
) (
    input logic                    clk,
    input logic                    rst,
    input logic                    cen6,
    input btiger_pkg::vid_timing_t timing
);

    // Counters stay inside the frame
    a_h_range: assert property (@(posedge clk) disable iff (rst) int'(timing.h) < H_TOTAL)
        else $error("h count %0d is past the line length", timing.h);
    a_v_range: assert property (@(posedge clk) disable iff (rst) int'(timing.v) < V_TOTAL)
        else $error("v count %0d is past the frame length", timing.v);

    // Pixel strobe is one clock wide
    a_cen6_width: assert property (@(posedge clk) disable iff (rst) cen6 |=> !cen6)
        else $error("cen6 high on two clocks in a row");

    a_hinit_h0: assert property (@(posedge clk) disable iff (rst) timing.hinit |-> timing.h == '0)
        else $error("hinit high while h is %0d", timing.h);

endmodule

bind btiger_timer btiger_assert #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)) u_timer_assert (
    .clk(clk), .rst(rst), .cen6(cen6), .timing(timing)
);

`default_nettype wire

// File: verification/btiger_tb.sv
`timescale 1ns/100ps
`default_nettype none

module btiger_tb;

    import btiger_pkg::*;

    localparam int     CLK_PERIOD   = 100;
    localparam longint FRAME_CYCLES = longint'(H_TOTAL) * V_TOTAL * 8;

    logic          clk;
    logic          rst;
    dl_addr_t      ioctl_addr;
    logic [21:0]   prog_addr;
    logic [7:0]    prog_data;
    logic          prom_we;
    layer_pixels_t pixels;
    logic          pxl2_cen;
    logic          pxl_cen;
    logic          cen3;
    vid_timing_t   timing;
    pal_idx_t      color;
    logic          mcu_we;
    logic [11:0]   mcu_addr;
    logic [7:0]    mcu_data;
    logic [21:0]   post_addr;

    // Pending comparisons, drained by the comparing process
    string       name_q[$];
    logic [63:0] exp_q[$];
    logic [63:0] act_q[$];

    logic [3:0] prom_copy [0:255];
    int errors = 0;
    int err_mark = 0;
    int tests_run = 0;
    int tests_failed = 0;

    btiger_video_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Strobes for a cycle counted from the edge that releases reset
    function automatic logic [2:0] strobe_ref(input int cyc);
        int c;
        c = (cyc - 1) % 16;
        return {c % 4 == 3, c % 8 == 7, c == 15};
    endfunction

    function automatic logic [4:0] flags_ref(input int h, input int v);
        return {h < H_ACTIVE, v >= V_ACT_START && v < V_ACT_END,
                h >= HS_START && h < HS_END, v >= VS_START && v < VS_END, h == 0 && v != 0};
    endfunction

    function automatic logic [21:0] post_ref(input dl_addr_t a, input logic [21:0] pa);
        logic [21:0] r;
        r = pa;
        if (a >= OBJ_START) begin
            r[5:2] = pa[4:1];
            r[1]   = pa[5];
        end
        return r;
    endfunction

    function automatic pal_idx_t mix_ref(input layer_pixels_t p, input logic active);
        if (!active) return '0;
        if (p.chr[3:0] != 4'hF) return {2'b01, p.chr};
        if (p.obj[3:0] != 4'hF && !prom_copy[p.scr][0]) return {2'b11, p.obj};
        return {2'b10, p.scr};
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic expect_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    always @(posedge clk) begin
        while (exp_q.size() > 0) begin
            check(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
        end
    end

    task automatic end_test(input string name);
        @(posedge clk);
        @(negedge clk);
        tests_run++;
        if (errors != err_mark) tests_failed++;
        $display("Test %s finished with %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // Returns after a cen6 edge, with the blanking that edge sampled
    task automatic next_pixel(output logic active);
        do @(negedge clk); while (!pxl_cen);
        active = timing.lhbl && timing.lvbl;
        @(posedge clk);
    endtask

    // Position 0 is the active area, 1 horizontal blank, 2 vertical blank inside the line
    task automatic wait_position(input int pos);
        logic h_act;
        logic h_blank;
        do begin
            @(negedge clk);
            h_act   = timing.h < hcnt_t'(H_ACTIVE - 16);
            h_blank = (timing.h >= hcnt_t'(H_ACTIVE)) && (timing.h < hcnt_t'(H_TOTAL - 16));
        end while (!((pos == 0) ? (timing.lvbl && h_act)
                   : (pos == 1) ? h_blank
                   : (!timing.lvbl && h_act)));
    endtask

    task automatic pixel_test(input layer_pixels_t px, output pal_idx_t exp, output logic act);
        logic skip;
        next_pixel(skip);
        pixels <= px;
        next_pixel(skip);
        next_pixel(skip);
        // Third hold strobe feeds the last registered color
        next_pixel(act);
        next_pixel(skip);
        @(negedge clk);
        exp = mix_ref(px, act);
        expect_val($sformatf("color for pixels %h", px), 64'(exp), 64'(color));
    endtask

    function automatic layer_pixels_t rand_pixels();
        layer_pixels_t px;
        px.chr = ($urandom % 3 == 0) ? 8'($urandom) : {4'($urandom), 4'hF};
        px.scr = 8'($urandom);
        px.obj = ($urandom % 2 == 0) ? 8'($urandom) : {4'($urandom), 4'hF};
        return px;
    endfunction

    task automatic check_strobes();
        for (int cyc = 1; cyc <= 64; cyc++) begin
            @(negedge clk);
            expect_val($sformatf("strobes cycle %0d", cyc), 64'(strobe_ref(cyc)),
                       64'({pxl2_cen, pxl_cen, cen3}));
        end
        end_test("strobes");
    endtask

    task automatic check_frame();
        int  ph;
        int  pv;
        int  eh;
        int  ev;
        logic act;
        next_pixel(act);
        @(negedge clk);
        ph = int'(timing.h);
        pv = int'(timing.v);
        for (int i = 0; i < H_TOTAL * V_TOTAL; i++) begin
            next_pixel(act);
            @(negedge clk);
            eh = (ph + 1) % H_TOTAL;
            ev = (ph == H_TOTAL - 1) ? (pv + 1) % V_TOTAL : pv;
            expect_val("timing", 64'({hcnt_t'(eh), vcnt_t'(ev), flags_ref(eh, ev)}), 64'(timing));
            ph = int'(timing.h);
            pv = int'(timing.v);
        end
        end_test("timing");
    endtask

    task automatic check_loader(input int count);
        dl_addr_t    a;
        logic [21:0] pa;
        logic [7:0]  d;
        logic        we;
        logic        exp_we;
        for (int i = 0; i < count; i++) begin
            case ($urandom % 4)
                0: a = OBJ_START - dl_addr_t'(1 + $urandom % 256);
                1: a = OBJ_START + dl_addr_t'($urandom % 256);
                2: a = MCU_OVER - dl_addr_t'(1 + $urandom % 256);
                default: a = MCU_OVER + dl_addr_t'((($urandom % 4) << 8) + $urandom % 256);
            endcase
            pa = 22'($urandom);
            d = 8'($urandom);
            we = ($urandom % 4) != 0;
            exp_we = we && (a < MCU_OVER);
            @(posedge clk);
            ioctl_addr <= a;
            prog_addr <= pa;
            prog_data <= d;
            prom_we <= we;
            @(negedge clk);
            expect_val("post_addr", 64'(post_ref(a, pa)), 64'(post_addr));
            @(posedge clk);
            prom_we <= 1'b0;
            @(negedge clk);
            expect_val("mcu_we", 64'(exp_we), 64'(mcu_we));
            if (exp_we) expect_val("mcu write", 64'({pa[11:0], d}), 64'({mcu_addr, mcu_data}));
        end
        end_test("loader");
    endtask

    task automatic load_prom();
        logic [3:0] d;
        for (int i = 0; i < 256; i++) begin
            d = 4'($urandom);
            prom_copy[i] = d;
            @(posedge clk);
            ioctl_addr <= MCU_OVER + dl_addr_t'(i);
            prog_addr <= 22'(i);
            prog_data <= {4'($urandom), d};
            prom_we <= 1'b1;
        end
        // Pages 1 to 3 carry inverted data that never reaches the PROM
        for (int i = 0; i < 256; i++) begin
            @(posedge clk);
            ioctl_addr <= MCU_OVER + dl_addr_t'(((1 + $urandom % 3) << 8) + i);
            prog_addr <= 22'(i);
            prog_data <= {4'($urandom), ~prom_copy[i]};
            prom_we <= 1'b1;
        end
        @(posedge clk);
        prom_we <= 1'b0;
    endtask

    task automatic check_mixer(input int count);
        pal_idx_t exp;
        logic     act;
        int       wins [4];
        wins = '{0, 0, 0, 0};
        for (int i = 0; i < count; i++) begin
            wait_position(0);
            pixel_test(rand_pixels(), exp, act);
            wins[int'(exp[9:8])]++;
        end
        if (wins[1] == 0 || wins[2] == 0 || wins[3] == 0) begin
            $display("Mixer test did not reach all three winning layers");
            errors++;
        end
        end_test("mixer priority");
    endtask

    task automatic check_blanking(input int count);
        pal_idx_t exp;
        logic     act;
        for (int i = 0; i < count; i++) begin
            wait_position(1 + i % 2);
            pixel_test(rand_pixels(), exp, act);
            expect_val("blanking sampled", 64'(0), 64'(act));
        end
        end_test("mixer blanking");
    endtask

    // Two frames cover the frame sweep and the waits for the active and blanking areas
    initial begin
        #(CLK_PERIOD * (2 * FRAME_CYCLES + 50000));
        $display("Timeout: the tests did not finish within two frames");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h438c));
        rst = 1'b1;
        ioctl_addr = '0;
        prog_addr = '0;
        prog_data = '0;
        prom_we = 1'b0;
        pixels = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        check_strobes();
        check_frame();
        check_loader(200);
        load_prom();
        check_mixer(48);
        check_blanking(16);
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: btiger_video.f
design/btiger_pkg.sv
design/btiger_cen.sv
design/btiger_timer.sv
design/btiger_rom_loader.sv
design/btiger_prio_mix.sv
design/btiger_video_top.sv
verification/btiger_assert.sv
verification/btiger_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := btiger_tb
FILELIST  := btiger_video.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(filter-out +%,$(shell cat $(FILELIST)))
PASS_MSG  := ALL TESTS PASSED
FAIL_MSG  := SOME TESTS FAILED

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "$(FAIL_MSG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
